//--- Bender.yml
package:
  name: rv32_core

sources:
  - hw/rv32_pkg.sv
  - hw/rv32_decoder.sv
  - hw/rv32_alu.sv
  - hw/rv32_regfile.sv
  - hw/rv32_data_mem.sv
  - hw/rv32_core.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/rv32_tb.sv

//--- hw/rv32_alu.sv
`timescale 1ns/100ps
// ************************************************************
// RV32I ALU and branch unit
// Operand selection, integer functions and branch conditions
// ************************************************************
module rv32_alu import rv32_pkg::*; (
  input  xlen_t   pc,
  input  xlen_t   rs1_data,
  input  xlen_t   rs2_data,
  input  xlen_t   imm,
  input  alu_op_e alu_op,
  input  logic    op1_pc,
  input  logic    op2_imm,
  input  funct3_t funct3,
  input  pc_sel_e pc_sel,
  output xlen_t   alu_result,
  output logic    branch_taken
);
  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  logic       cond;  // Branch condition on raw register values

  assign op_a  = op1_pc ? pc : rs1_data;
  assign op_b  = op2_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {31'b0, ($signed(op_a) < $signed(op_b))};
      ALU_SLTU: alu_result = {31'b0, (op_a < op_b)};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  cond = (rs1_data == rs2_data);
      F3_BNE:  cond = (rs1_data != rs2_data);
      F3_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: cond = (rs1_data < rs2_data);
      F3_BGEU: cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = (pc_sel == PC_JUMP) ||
                        ((pc_sel == PC_BRANCH) && cond);

endmodule

//--- hw/rv32_core.sv
`timescale 1ns/100ps
// ************************************************************
// Single-cycle RV32I core
// Program counter, next-PC choice and register write-back
// ************************************************************
module rv32_core import rv32_pkg::*; #(
  parameter int DMEM_ADDR_BITS = 12
) (
  input  logic       clock,
  input  logic       reset_n,
  input  xlen_t      fetch_data,
  output xlen_t      fetch_addr,
  output logic       store_valid,
  output xlen_t      store_addr,
  output xlen_t      store_data,
  output logic [3:0] store_strb
);
  xlen_t     pc;
  xlen_t     pc_plus4;
  xlen_t     pc_next;
  reg_addr_t rs1_addr, rs2_addr, rd_addr;
  xlen_t     imm;
  alu_op_e   alu_op;
  logic      op1_pc, op2_imm;
  funct3_t   funct3;
  logic      mem_read, mem_write, rf_wen;
  logic      store_en;
  wb_sel_e   wb_sel;
  pc_sel_e   pc_sel;
  xlen_t     rs1_data, rs2_data;
  xlen_t     alu_result;
  logic      branch_taken;
  xlen_t     load_data;
  xlen_t     rd_data;

  assign fetch_addr = pc;
  assign pc_plus4   = pc + INSTR_BYTES;
  assign pc_next    = branch_taken ? {alu_result[31:1], 1'b0} : pc_plus4;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign store_en = mem_write & reset_n;  // No store while held in reset

  always_comb begin
    case (wb_sel)
      WB_MEM:  rd_data = load_data;
      WB_LINK: rd_data = pc_plus4;  // Return address
      default: rd_data = alu_result;
    endcase
  end

  rv32_decoder dec0 (
    .instr(fetch_data), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .imm(imm), .alu_op(alu_op), .op1_pc(op1_pc), .op2_imm(op2_imm), .funct3(funct3),
    .mem_read(mem_read), .mem_write(mem_write), .rf_wen(rf_wen), .wb_sel(wb_sel),
    .pc_sel(pc_sel)
  );

  rv32_regfile rf0 (
    .clock(clock), .reset_n(reset_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rd_addr(rd_addr), .rd_data(rd_data), .rd_wen(rf_wen),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv32_alu alu0 (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_op(alu_op),
    .op1_pc(op1_pc), .op2_imm(op2_imm), .funct3(funct3), .pc_sel(pc_sel),
    .alu_result(alu_result), .branch_taken(branch_taken)
  );

  rv32_data_mem #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) dmem0 (
    .clock(clock), .addr(alu_result), .wdata(rs2_data), .funct3(funct3),
    .mem_read(mem_read), .mem_write(store_en), .load_data(load_data),
    .store_addr(store_addr), .store_data(store_data), .store_strb(store_strb),
    .store_valid(store_valid)
  );

endmodule

//--- hw/rv32_data_mem.sv
`timescale 1ns/100ps
// ************************************************************
// Byte-addressed data memory with load extension and store port
// ************************************************************
module rv32_data_mem import rv32_pkg::*; #(
  parameter int DMEM_ADDR_BITS = 12
) (
  input  logic       clock,
  input  xlen_t      addr,
  input  xlen_t      wdata,
  input  funct3_t    funct3,
  input  logic       mem_read,
  input  logic       mem_write,
  output xlen_t      load_data,
  output xlen_t      store_addr,
  output xlen_t      store_data,
  output logic [3:0] store_strb,
  output logic       store_valid
);
  localparam int DMEM_BYTES = 1 << DMEM_ADDR_BITS;

  logic [7:0]                mem [DMEM_BYTES];
  logic [DMEM_ADDR_BITS-3:0] word_addr;  // Wraps modulo memory size
  logic [1:0]                byte_off;
  xlen_t                     rd_word;
  xlen_t                     shifted;
  xlen_t                     load_val;
  logic [3:0]                size_strb;

  assign word_addr = addr[DMEM_ADDR_BITS-1:2];
  assign byte_off  = addr[1:0];

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      rd_word[8*b +: 8] = mem[{word_addr, 2'(b)}];  // Little endian
    end
  end

  assign shifted = rd_word >> {byte_off, 3'b000};

  always_comb begin
    case (funct3)
      F3_BYTE:   load_val = {{24{shifted[7]}}, shifted[7:0]};
      F3_HALF:   load_val = {{16{shifted[15]}}, shifted[15:0]};
      F3_WORD:   load_val = shifted;
      F3_BYTE_U: load_val = {24'b0, shifted[7:0]};
      F3_HALF_U: load_val = {16'b0, shifted[15:0]};
      default:   load_val = '0;
    endcase
  end

  assign load_data = mem_read ? load_val : '0;

  always_comb begin
    case (funct3)
      F3_BYTE: size_strb = 4'b0001;
      F3_HALF: size_strb = 4'b0011;
      F3_WORD: size_strb = 4'b1111;
      default: size_strb = 4'b0000;
    endcase
  end

  assign store_valid = mem_write;
  assign store_addr  = {addr[31:2], 2'b00};
  assign store_data  = wdata << {byte_off, 3'b000};  // Move into byte lanes
  assign store_strb  = mem_write ? (size_strb << byte_off) : 4'b0000;

  always_ff @(posedge clock) begin
    for (int b = 0; b < 4; b++) begin
      if (store_strb[b]) begin
        mem[{word_addr, 2'(b)}] <= store_data[8*b +: 8];
      end
    end
  end

endmodule

//--- hw/rv32_decoder.sv
`timescale 1ns/100ps
// ************************************************************
// RV32I instruction decoder
// Splits an instruction into register fields, immediate and control
// ************************************************************
module rv32_decoder import rv32_pkg::*; (
  input  xlen_t     instr,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output reg_addr_t rd_addr,
  output xlen_t     imm,
  output alu_op_e   alu_op,
  output logic      op1_pc,
  output logic      op2_imm,
  output funct3_t   funct3,
  output logic      mem_read,
  output logic      mem_write,
  output logic      rf_wen,
  output wb_sel_e   wb_sel,
  output pc_sel_e   pc_sel
);
  opcode_e    opcode;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       reg_ok;  // Legal funct7 for register-register ops
  logic       imm_ok;  // Legal funct7 for shift immediates

  function automatic alu_op_e alu_sel(input funct3_t f3, input logic alt_add,
                                      input logic alt_shr);
    case (f3)
      3'b000:  return alt_add ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt_shr ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode   = opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Only SUB and SRA may set bit 30
  assign reg_ok = (funct7 == 7'b0) ||
                  ((funct7 == 7'b0100000) && (funct3 inside {3'b000, 3'b101}));
  assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0) :
                  (funct3 == 3'b101) ? ((funct7 == 7'b0) || (funct7 == 7'b0100000)) :
                  1'b1;

  always_comb begin
    rs1_addr  = instr[19:15];
    imm       = '0;
    alu_op    = ALU_ADD;
    op1_pc    = 1'b0;
    op2_imm   = 1'b1;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    rf_wen    = 1'b0;
    wb_sel    = WB_ALU;
    pc_sel    = PC_SEQ;
    case (opcode)
      OP_REG: begin
        op2_imm = 1'b0;
        alu_op  = alu_sel(funct3, instr[30], instr[30]);
        rf_wen  = reg_ok;
      end
      OP_IMM: begin
        imm    = imm_i;
        alu_op = alu_sel(funct3, 1'b0, instr[30]);  // ADDI never subtracts
        rf_wen = imm_ok;
      end
      OP_LOAD: begin
        imm      = imm_i;
        mem_read = funct3 inside {F3_BYTE, F3_HALF, F3_WORD, F3_BYTE_U, F3_HALF_U};
        rf_wen   = mem_read;
        wb_sel   = WB_MEM;
      end
      OP_STORE: begin
        imm       = imm_s;
        mem_write = funct3 inside {F3_BYTE, F3_HALF, F3_WORD};
      end
      OP_BRANCH: begin
        imm    = imm_b;
        op1_pc = 1'b1;  // Target is PC relative
        pc_sel = (funct3 inside {3'b010, 3'b011}) ? PC_SEQ : PC_BRANCH;
      end
      OP_LUI: begin
        rs1_addr = '0;  // Immediate plus zero
        imm      = imm_u;
        rf_wen   = 1'b1;
      end
      OP_AUIPC: begin
        imm    = imm_u;
        op1_pc = 1'b1;
        rf_wen = 1'b1;
      end
      OP_JAL: begin
        imm    = imm_j;
        op1_pc = 1'b1;
        rf_wen = 1'b1;
        wb_sel = WB_LINK;
        pc_sel = PC_JUMP;
      end
      OP_JALR: begin
        imm    = imm_i;
        rf_wen = (funct3 == 3'b000);
        wb_sel = WB_LINK;
        pc_sel = (funct3 == 3'b000) ? PC_JUMP : PC_SEQ;
      end
      default: begin
        // System, fence and unknown opcodes fall through as no-ops
      end
    endcase
  end

endmodule

//--- hw/rv32_pkg.sv
// ************************************************************
// RV32I core shared types
// Word and register index types, opcode and control encodings
// ************************************************************
package rv32_pkg;

  localparam int XLEN          = 32;
  localparam int REG_ADDR_BITS = 5;

  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [2:0]               funct3_t;

  localparam xlen_t INSTR_BYTES = 32'd4;  // PC step

  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011,
    OP_FENCE  = 7'b0001111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_sel_e;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Memory access size and signedness
  localparam funct3_t F3_BYTE   = 3'b000;
  localparam funct3_t F3_HALF   = 3'b001;
  localparam funct3_t F3_WORD   = 3'b010;
  localparam funct3_t F3_BYTE_U = 3'b100;
  localparam funct3_t F3_HALF_U = 3'b101;

endpackage

//--- hw/rv32_regfile.sv
`timescale 1ns/100ps
// ************************************************************
// RV32I register file, two read ports and one write port
// ************************************************************
module rv32_regfile import rv32_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  xlen_t     rd_data,
  input  logic      rd_wen,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data
);
  xlen_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- rv32_core.f
hw/rv32_pkg.sv
hw/rv32_decoder.sv
hw/rv32_alu.sv
hw/rv32_regfile.sv
hw/rv32_data_mem.sv
hw/rv32_core.sv
tests/tb_clock.sv
tests/rv32_tb.sv

//--- tests/rv32_cases.hex
// Word 0 is the case count. Each case: program length, program words, cycle budget,
// expected store count, then address, data and strobe of each store in order
00000006
// Case 1: ALU operations
00000015 F00000B7 0F008093 00400113 4020D1B3 10302023 0020D233 10402223
401102B3 10502423 0020A333 0020B3B3 10602623 10702823 FFF0C413 10802A23
0FF0F493 0024E533 10A02C23 01C11593 10B02E23 0000006F
00000028 00000008
00000100 FF00000F 0000000F 00000104 0F00000F 0000000F 00000108 0FFFFF14 0000000F
0000010C 00000001 0000000F 00000110 00000000 0000000F 00000114 0FFFFF0F 0000000F
00000118 000000F4 0000000F 0000011C 40000000 0000000F
// Case 2: byte and halfword stores, load extension
00000010 78500093 80D00113 20100023 201000A3 20201123 20100183 20104203
20201283 20205303 20002383 20302823 20402A23 20502C23 20602E23 22702023
0000006F
00000020 00000008
00000200 00000785 00000001 00000200 00078500 00000002 00000200 F80D0000 0000000C
00000210 FFFFFF85 0000000F 00000214 00000085 0000000F 00000218 FFFFF80D 0000000F
0000021C 0000F80D 0000000F 00000220 F80D8585 0000000F
// Case 3: six branches taken and not taken, then a three pass loop
0000001F FFF00093 00100113 00210463 3E002823 00208463 30202023 00209463
3E002823 00211463 30202223 0020C463 3E002823 00114463 30202423 00115463
3E002823 0020D463 30202623 00116463 3E002823 0020E463 30202823 0020F463
3E002823 00117463 30202A23 00300213 00118193 FE419EE3 32302823 0000006F
00000032 00000007
00000300 00000001 0000000F 00000304 00000001 0000000F 00000308 00000001 0000000F
0000030C 00000001 0000000F 00000310 00000001 0000000F 00000314 00000001 0000000F
00000330 00000003 0000000F
// Case 4: AUIPC, JAL and JALR with link values
0000000D 00000013 12345097 40102023 00C0016F 3E002823 3E002823 40202223
02800193 00518267 3E002823 3E002823 40402423 0000006F
00000019 00000003
00000400 12345004 0000000F 00000404 00000010 0000000F 00000408 00000024 0000000F
// Case 5: writes to x0, ECALL, EBREAK and FENCE
0000000B 05500013 00000073 0FF0000F 50002023 07A00093 00100073 0FF0000F
50102223 ABCDE037 50002423 0000006F
00000019 00000003
00000500 00000000 0000000F 00000504 0000007A 0000000F 00000508 00000000 0000000F
// Case 6: store as the very first instruction after reset
00000004 60002023 00000097 60102223 0000006F
0000000C 00000002
00000600 00000000 0000000F 00000604 00000004 0000000F

//--- tests/rv32_tb.sv
`timescale 1ns/100ps
// ************************************************************
// Testbench for the single-cycle RV32I core
// Runs programs from a case file and checks the store sequence
// ************************************************************
module rv32_tb;
  localparam int          CLOCK_PERIOD    = 20;
  localparam int          RESET_CYCLES    = 16;
  localparam int          DRIVE_DELAY     = 2;     // ns after the rising edge
  localparam int          WATCHDOG_MARGIN = 2000;  // ns
  localparam int          FILE_WORDS      = 1024;
  localparam int          PROG_WORDS      = 256;
  localparam int          MAX_STORES      = 64;
  localparam logic [31:0] HALT_INSTR      = 32'h0000006F;  // jal x0, 0

  logic        clock;
  logic        reset_n;
  logic [31:0] fetch_data;
  logic [31:0] fetch_addr;
  logic        store_valid;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  logic [3:0]  store_strb;

  logic [31:0] file_words [FILE_WORDS];
  logic [31:0] prog [PROG_WORDS];
  int          prog_len;
  int          rd_ptr;   // Next unread word of the case file
  int          errors;   // Failures in the running case
  int          cases_passed;
  int          cases_failed;

  tb_clock #(.PERIOD_NS(CLOCK_PERIOD)) clk0 (.clock(clock));

  rv32_core dut0 (
    .clock(clock), .reset_n(reset_n), .fetch_data(fetch_data), .fetch_addr(fetch_addr),
    .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
    .store_strb(store_strb)
  );

  // Past the end of the program the core spins on a halt loop
  assign fetch_data = (fetch_addr < 32'(4 * prog_len)) ? prog[fetch_addr[9:2]] : HALT_INSTR;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic int count_cycles(input int n_cases);
    int p;
    int total;
    p = 1;
    total = 0;
    for (int c = 0; c < n_cases; c++) begin
      p = p + 1 + int'(file_words[p]);  // Skip the program
      total += int'(file_words[p]) + RESET_CYCLES + 2;
      p = p + 2 + 3 * int'(file_words[p + 1]);
    end
    return total;
  endfunction

  task automatic watchdog(input int cycles);
    #(cycles * CLOCK_PERIOD + WATCHDOG_MARGIN);
    $display("Timeout: the run went past its limit of %0d clock cycles", cycles);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic run_case(input int number);
    int          budget;
    int          n_exp;
    int          seen;
    logic [31:0] exp_addr [MAX_STORES];
    logic [31:0] exp_data [MAX_STORES];
    logic [3:0]  exp_strb [MAX_STORES];
    errors = 0;
    seen   = 0;
    @(posedge clock);
    #(DRIVE_DELAY);
    reset_n  = 1'b0;
    prog_len = file_words[rd_ptr];
    for (int i = 0; i < prog_len; i++) begin
      prog[i] = file_words[rd_ptr + 1 + i];
    end
    rd_ptr += 1 + prog_len;
    budget  = file_words[rd_ptr];
    n_exp   = file_words[rd_ptr + 1];
    rd_ptr += 2;
    for (int i = 0; i < n_exp; i++) begin
      exp_addr[i] = file_words[rd_ptr];
      exp_data[i] = file_words[rd_ptr + 1];
      exp_strb[i] = file_words[rd_ptr + 2][3:0];
      rd_ptr += 3;
    end
    repeat (RESET_CYCLES) begin
      @(negedge clock);
      if (store_valid !== 1'b0) begin
        $display("Case %0d: a store was driven while reset was held", number);
        errors++;
      end
    end
    @(posedge clock);
    #(DRIVE_DELAY);
    reset_n = 1'b1;
    for (int cyc = 0; cyc < budget; cyc++) begin
      @(negedge clock);  // Mid-cycle, outputs settled
      if (cyc == 0) begin
        check_value("first fetch address", fetch_addr, 32'h0);
      end
      check_value("fetch address bit 0", {31'b0, fetch_addr[0]}, 32'h0);  // Targets drop bit 0
      if (store_valid === 1'b1) begin
        if (seen < n_exp) begin
          check_value("store address", store_addr, exp_addr[seen]);
          check_value("store data", store_data, exp_data[seen]);
          check_value("store strobe", store_strb, exp_strb[seen]);
        end else begin
          $display("Case %0d: a store to %h was not expected", number, store_addr);
          errors++;
        end
        seen++;
      end
    end
    if (seen < n_exp) begin
      $display("Case %0d: %0d of %0d expected stores never appeared", number,
               n_exp - seen, n_exp);
      errors++;
    end
    if (errors == 0) begin
      cases_passed++;
      $display("Case %0d passed, %0d stores checked", number, seen);
    end else begin
      cases_failed++;
      $display("Case %0d failed with %0d errors", number, errors);
    end
  endtask

  initial begin
    int n_cases;
    int total;
    reset_n      = 1'b0;
    prog_len     = 0;
    errors       = 0;
    cases_passed = 0;
    cases_failed = 0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = HALT_INSTR;
    end
    $readmemh("tests/rv32_cases.hex", file_words);
    if ($isunknown(file_words[0])) begin
      $display("The case file tests/rv32_cases.hex could not be read");
      $display("TEST FAIL");
      $finish;
    end else begin
      n_cases = file_words[0];
      total   = count_cycles(n_cases);
      fork
        watchdog(total);
      join_none
      rd_ptr = 1;
      for (int c = 1; c <= n_cases; c++) begin
        run_case(c);
      end
      $display("Cases passed: %0d, failed: %0d", cases_passed, cases_failed);
      if (cases_failed == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/100ps
// ************************************************************
// Free-running testbench clock
// ************************************************************
module tb_clock #(
  parameter real PERIOD_NS = 20.0
) (
  output logic clock
);
  initial begin
    clock = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clock = ~clock;
    end
  end
endmodule
